//--- Makefile
# Verilator build and run of the serial bridge testbench

VERILATOR ?= verilator
TOP       ?= tb_serial_bridge
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SRCS    := $(shell cat $(FLIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# the exit status comes from the search for the pass line
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST PASSED$$"

clean:
	rm -rf $(OBJ_DIR)

//--- flist.f
src/serial_bridge_pkg.sv
src/spi_byte_shifter.sv
src/reply_fifo.sv
src/ctrl_sync.sv
src/wb_reg_file.sv
src/serial_bridge_top.sv
verification/tb_serial_bridge.sv

//--- src/ctrl_sync.sv
`timescale 1ns/1ns

// command fsm turning the received byte stream into wishbone single cycles
//
// single read, address in the low nibble of the command
//   host:   0xxx_aaaa  filler     filler     (filler)
//   reply:  --         00         01         data
//
// single write
//   host:   1xxx_aaaa  data       filler     (filler)
//   reply:  --         00         00         01
//
// each reply is queued while its byte is received and shifted out during
// the byte that follows it
module ctrl_sync (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,

  // byte stream from and to the spi side
  input  logic [serial_bridge_pkg::byte_w-1:0] rx_data_i,
  input  logic                                 rx_req_i,
  output logic [serial_bridge_pkg::byte_w-1:0] tx_data_o,
  output logic                                 tx_req_o,

  // wishbone b4 controller
  output logic                                 wb_we_o,
  output logic                                 wb_stb_o,
  output logic [serial_bridge_pkg::adr_w-1:0]  wb_adr_o,
  output logic [serial_bridge_pkg::byte_w-1:0] wb_dat_o,
  input  logic                                 wb_ack_i,
  input  logic [serial_bridge_pkg::byte_w-1:0] wb_dat_i
);
  logic [serial_bridge_pkg::ctrl_state_w-1:0] state_q;
  logic [serial_bridge_pkg::ctrl_state_w-1:0] state_d;
  logic                                       we_q;
  logic                                       we_d;
  logic [serial_bridge_pkg::adr_w-1:0]        adr_q;
  logic [serial_bridge_pkg::adr_w-1:0]        adr_d;
  logic                                       stb;
  logic                                       ack_q;
  logic [serial_bridge_pkg::byte_w-1:0]       rd_q;

  // every received byte queues exactly one reply byte
  assign tx_req_o = rx_req_i;

  // the strobe goes out in the same cycle as the byte that starts the cycle,
  // so address and direction come from the next state values
  assign wb_stb_o = stb;
  assign wb_we_o  = we_d;
  assign wb_adr_o = adr_d;
  // write data is the data byte itself, sampled only on a write strobe
  assign wb_dat_o = rx_data_i;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= serial_bridge_pkg::ctrl_st_idle;
      we_q    <= 1'b0;
      adr_q   <= '0;
    end else begin
      state_q <= state_d;
      we_q    <= we_d;
      adr_q   <= adr_d;
    end
  end

  // the acknowledge lands long before the next byte, so it is kept until
  // the fsm looks at it, and a new strobe clears the old one
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
    end else if (wb_ack_i) begin
      ack_q <= 1'b1;
    end else if (stb) begin
      ack_q <= 1'b0;
    end
  end

  // read data stays put until the next acknowledge
  always_ff @(posedge clk_i) begin
    if (wb_ack_i) begin
      rd_q <= wb_dat_i;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // next state and reply, evaluated only when a byte arrives
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    state_d   = state_q;
    we_d      = we_q;
    adr_d     = adr_q;
    stb       = 1'b0;
    tx_data_o = serial_bridge_pkg::reply_idle;

    if (rx_req_i) begin
      case (state_q)
        serial_bridge_pkg::ctrl_st_idle: begin
          // bits above the address nibble other than the write flag are ignored
          adr_d = rx_data_i[serial_bridge_pkg::adr_w-1:0];
          we_d  = rx_data_i[serial_bridge_pkg::cmd_write_bit];
          if (we_d) begin
            state_d = serial_bridge_pkg::ctrl_st_write_get_data;
          end else begin
            stb     = 1'b1;
            state_d = serial_bridge_pkg::ctrl_st_read_wait_ack;
          end
        end

        serial_bridge_pkg::ctrl_st_write_get_data: begin
          stb     = 1'b1;
          state_d = serial_bridge_pkg::ctrl_st_write_wait_ack;
        end

        serial_bridge_pkg::ctrl_st_write_wait_ack: begin
          if (ack_q) begin
            tx_data_o = serial_bridge_pkg::reply_ack;
            state_d   = serial_bridge_pkg::ctrl_st_idle;
          end
        end

        serial_bridge_pkg::ctrl_st_read_wait_ack: begin
          if (ack_q) begin
            tx_data_o = serial_bridge_pkg::reply_ack;
            state_d   = serial_bridge_pkg::ctrl_st_read_put_data;
          end
        end

        serial_bridge_pkg::ctrl_st_read_put_data: begin
          tx_data_o = rd_q;
          state_d   = serial_bridge_pkg::ctrl_st_idle;
        end

        // an unknown encoding recovers at the next byte
        default: begin
          state_d = serial_bridge_pkg::ctrl_st_idle;
        end
      endcase
    end
  end

endmodule

//--- src/reply_fifo.sv
`timescale 1ns/1ns

// circular buffer of reply bytes waiting to be shifted out
module reply_fifo (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 push_i,
  input  logic [serial_bridge_pkg::byte_w-1:0] push_data_i,
  input  logic                                 pop_i,
  output logic [serial_bridge_pkg::byte_w-1:0] pop_data_o,
  output logic                                 empty_o
);
  logic [serial_bridge_pkg::byte_w-1:0] mem [serial_bridge_pkg::fifo_depth];
  logic [serial_bridge_pkg::fifo_ptr_w-1:0] wr_ptr;
  logic [serial_bridge_pkg::fifo_ptr_w-1:0] rd_ptr;
  logic [serial_bridge_pkg::fifo_ptr_w:0]   count;
  logic                                     full;
  logic                                     do_push;
  logic                                     do_pop;

  // the count is one bit wider than the pointers to tell full from empty
  assign full    = (count == (serial_bridge_pkg::fifo_ptr_w + 1)'(serial_bridge_pkg::fifo_depth));
  assign empty_o = (count == '0);

  // a push into a full buffer is lost, a pop from an empty one does nothing
  assign do_push = push_i & ~full;
  assign do_pop  = pop_i & ~empty_o;

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data_i;
    end
  end

  // pointers wrap naturally since the depth is a power of two
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // head of the queue, valid whenever the buffer is not empty
  assign pop_data_o = mem[rd_ptr];

endmodule

//--- src/serial_bridge_pkg.sv
// shared constants of the serial to wishbone bridge
package serial_bridge_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // data path widths
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // one serial byte is also one wishbone data word
  localparam int byte_w = 8;
  // the register file decodes the low four address bits only
  localparam int adr_w = 4;
  localparam int reg_count = 16;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // command byte fields and reply codes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // a set write flag selects a single write, a clear one a single read
  localparam int cmd_write_bit = 7;
  // the wishbone cycle has been acknowledged
  localparam logic [byte_w-1:0] reply_ack = 8'h01;
  // nothing to report yet, also shifted out when no reply is queued
  localparam logic [byte_w-1:0] reply_idle = 8'h00;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // buffering and synchronization
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int fifo_depth = 4;
  localparam int fifo_ptr_w = 2;
  // flops between each spi pin and the logic that uses it
  localparam int sync_stages = 2;

  // controller fsm encoding
  localparam int ctrl_state_w = 3;
  localparam logic [ctrl_state_w-1:0] ctrl_st_idle = 3'd0;
  localparam logic [ctrl_state_w-1:0] ctrl_st_read_wait_ack = 3'd1;
  localparam logic [ctrl_state_w-1:0] ctrl_st_read_put_data = 3'd2;
  localparam logic [ctrl_state_w-1:0] ctrl_st_write_get_data = 3'd3;
  localparam logic [ctrl_state_w-1:0] ctrl_st_write_wait_ack = 3'd4;

endpackage

//--- src/serial_bridge_top.sv
`timescale 1ns/1ns

// spi to wishbone bridge with a local register file
module serial_bridge_top (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic spi_sclk_i,
  input  logic spi_csn_i,
  input  logic spi_mosi_i,
  output logic spi_miso_o
);
  // received bytes towards the controller
  logic [serial_bridge_pkg::byte_w-1:0] rx_data;
  logic                                 rx_req;

  // reply bytes from the controller through the fifo
  logic [serial_bridge_pkg::byte_w-1:0] tx_data;
  logic                                 tx_req;
  logic [serial_bridge_pkg::byte_w-1:0] fifo_rd_data;
  logic                                 fifo_pop;
  logic                                 fifo_empty;

  // wishbone between controller and register file
  logic                                 wb_stb;
  logic                                 wb_we;
  logic [serial_bridge_pkg::adr_w-1:0]  wb_adr;
  logic [serial_bridge_pkg::byte_w-1:0] wb_dat_c2p;
  logic [serial_bridge_pkg::byte_w-1:0] wb_dat_p2c;
  logic                                 wb_ack;

  spi_byte_shifter shifter_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .sclk_i       (spi_sclk_i),
    .csn_i        (spi_csn_i),
    .mosi_i       (spi_mosi_i),
    .miso_o       (spi_miso_o),
    .rx_data_o    (rx_data),
    .rx_req_o     (rx_req),
    .fifo_pop_o   (fifo_pop),
    .fifo_data_i  (fifo_rd_data),
    .fifo_empty_i (fifo_empty)
  );

  reply_fifo fifo_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .push_i      (tx_req),
    .push_data_i (tx_data),
    .pop_i       (fifo_pop),
    .pop_data_o  (fifo_rd_data),
    .empty_o     (fifo_empty)
  );

  ctrl_sync ctrl_i (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .rx_data_i (rx_data),
    .rx_req_i  (rx_req),
    .tx_data_o (tx_data),
    .tx_req_o  (tx_req),
    .wb_we_o   (wb_we),
    .wb_stb_o  (wb_stb),
    .wb_adr_o  (wb_adr),
    .wb_dat_o  (wb_dat_c2p),
    .wb_ack_i  (wb_ack),
    .wb_dat_i  (wb_dat_p2c)
  );

  wb_reg_file regs_i (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wb_stb_i (wb_stb),
    .wb_we_i  (wb_we),
    .wb_adr_i (wb_adr),
    .wb_dat_i (wb_dat_c2p),
    .wb_ack_o (wb_ack),
    .wb_dat_o (wb_dat_p2c)
  );

endmodule

//--- src/spi_byte_shifter.sv
`timescale 1ns/1ns

// spi mode 0 target, one byte in and one byte out per eight clocks
module spi_byte_shifter (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 sclk_i,
  input  logic                                 csn_i,
  input  logic                                 mosi_i,
  output logic                                 miso_o,
  output logic [serial_bridge_pkg::byte_w-1:0] rx_data_o,
  output logic                                 rx_req_o,
  output logic                                 fifo_pop_o,
  input  logic [serial_bridge_pkg::byte_w-1:0] fifo_data_i,
  input  logic                                 fifo_empty_i
);
  logic [serial_bridge_pkg::sync_stages-1:0]   sclk_sync;
  logic [serial_bridge_pkg::sync_stages-1:0]   csn_sync;
  logic [serial_bridge_pkg::sync_stages-1:0]   mosi_sync;
  logic                                        sclk_s;
  logic                                        csn_s;
  logic                                        mosi_s;
  logic                                        sclk_q;
  logic                                        csn_q;
  logic                                        sclk_rise;
  logic                                        sclk_fall;
  logic                                        csn_fall;
  logic                                        tx_load;
  logic [$clog2(serial_bridge_pkg::byte_w)-1:0] bit_cnt;
  logic [serial_bridge_pkg::byte_w-1:0]        rx_shift;
  logic [serial_bridge_pkg::byte_w-1:0]        tx_shift;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // pin synchronizers and edge detection
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // chip select idles high, so its chain resets to ones
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      sclk_sync <= '0;
      csn_sync  <= '1;
      mosi_sync <= '0;
      sclk_q    <= 1'b0;
      csn_q     <= 1'b1;
    end else begin
      sclk_sync <= {sclk_sync[serial_bridge_pkg::sync_stages-2:0], sclk_i};
      csn_sync  <= {csn_sync[serial_bridge_pkg::sync_stages-2:0], csn_i};
      mosi_sync <= {mosi_sync[serial_bridge_pkg::sync_stages-2:0], mosi_i};
      sclk_q    <= sclk_s;
      csn_q     <= csn_s;
    end
  end

  assign sclk_s = sclk_sync[serial_bridge_pkg::sync_stages-1];
  assign csn_s  = csn_sync[serial_bridge_pkg::sync_stages-1];
  assign mosi_s = mosi_sync[serial_bridge_pkg::sync_stages-1];

  // all three pins see the same delay, so edges and select stay aligned
  assign sclk_rise = sclk_s & ~sclk_q;
  assign sclk_fall = ~sclk_s & sclk_q;
  assign csn_fall  = csn_q & ~csn_s;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // receive path
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // deselect drops any partial byte by clearing the bit count
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      bit_cnt  <= '0;
      rx_req_o <= 1'b0;
    end else begin
      rx_req_o <= 1'b0;
      if (csn_s) begin
        bit_cnt <= '0;
      end else if (sclk_rise) begin
        bit_cnt  <= bit_cnt + 1'b1;
        // the counter wraps to zero after the eighth bit
        rx_req_o <= &bit_cnt;
      end
    end
  end

  // msb arrives first
  always_ff @(posedge clk_i) begin
    if (sclk_rise && !csn_s) begin
      rx_shift <= {rx_shift[serial_bridge_pkg::byte_w-2:0], mosi_s};
    end
  end

  // rx_req rises the cycle after the last shift, so the register is complete
  assign rx_data_o = rx_shift;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // transmit path
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // a falling edge with a zero count closes a byte, since mode 0 has no falling
  // edge before the first bit of a transfer
  assign tx_load    = csn_fall | (sclk_fall & ~csn_s & (bit_cnt == '0));
  assign fifo_pop_o = tx_load & ~fifo_empty_i;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      tx_shift <= serial_bridge_pkg::reply_idle;
    end else if (tx_load) begin
      tx_shift <= fifo_empty_i ? serial_bridge_pkg::reply_idle : fifo_data_i;
    end else if (sclk_fall && !csn_s) begin
      tx_shift <= {tx_shift[serial_bridge_pkg::byte_w-2:0], 1'b0};
    end
  end

  assign miso_o = tx_shift[serial_bridge_pkg::byte_w-1];

endmodule

//--- src/wb_reg_file.sv
`timescale 1ns/1ns

// wishbone b4 peripheral with sixteen byte wide registers
module wb_reg_file (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 wb_stb_i,
  input  logic                                 wb_we_i,
  input  logic [serial_bridge_pkg::adr_w-1:0]  wb_adr_i,
  input  logic [serial_bridge_pkg::byte_w-1:0] wb_dat_i,
  output logic                                 wb_ack_o,
  output logic [serial_bridge_pkg::byte_w-1:0] wb_dat_o
);
  logic [serial_bridge_pkg::byte_w-1:0] regs [serial_bridge_pkg::reg_count];

  // registers power up cleared so reads right after reset return zero
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      for (int i = 0; i < serial_bridge_pkg::reg_count; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_stb_i && wb_we_i) begin
      regs[wb_adr_i] <= wb_dat_i;
    end
  end

  // every strobe is answered one cycle later, with no wait states
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      wb_ack_o <= 1'b0;
    end else begin
      wb_ack_o <= wb_stb_i;
    end
  end

  // read data lines up with the acknowledge
  always_ff @(posedge clk_i) begin
    if (wb_stb_i && !wb_we_i) begin
      wb_dat_o <= regs[wb_adr_i];
    end
  end

endmodule

//--- verification/tb_serial_bridge.sv
`timescale 1ns/1ns

// drives the bridge as an spi mode 0 host and checks every reply byte
module tb_serial_bridge;

  localparam int clk_half_ns = 4;
  // each spi clock phase lasts this many system clocks
  localparam int spi_half = 4;
  localparam int byte_cycles = 8 * 2 * spi_half;
  // select setup, deselect hold and the idle gap around one frame
  localparam int frame_overhead = 32;
  localparam logic [7:0] filler = 8'h00;

  logic clk;
  logic rst_n;
  logic spi_sclk;
  logic spi_csn;
  logic spi_mosi;
  logic spi_miso;

  // command, second and third byte of one transaction
  logic [23:0] stim_q [$];
  // the four collected replies where the first one is shifted out during the command
  logic [31:0] resp_q [$];
  logic [7:0]  model [serial_bridge_pkg::reg_count];
  logic [31:0] rnd;
  int          error_count;
  int          check_count;
  int          cycle_count = 0;
  int          cycle_limit;

  serial_bridge_top dut_i (
    .clk_i      (clk),
    .rst_ni     (rst_n),
    .spi_sclk_i (spi_sclk),
    .spi_csn_i  (spi_csn),
    .spi_mosi_i (spi_mosi),
    .spi_miso_o (spi_miso)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_half_ns) clk = ~clk;
  end

  // the limit is only known once the table is built and stays zero until then
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("TEST FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // table construction with the register model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // the bridge only decodes the low address nibble, so the model index wraps
  task automatic add_entry(input logic wr, input logic [7:0] adr, input logic [7:0] dat);
    logic [7:0] cmd;
    int         idx;
    cmd = adr;
    cmd[serial_bridge_pkg::cmd_write_bit] = wr;
    idx = int'(adr) % serial_bridge_pkg::reg_count;
    if (wr) begin
      model[idx] = dat;
      stim_q.push_back({cmd, dat, filler});
      resp_q.push_back({serial_bridge_pkg::reply_idle, serial_bridge_pkg::reply_idle,
                        serial_bridge_pkg::reply_idle, serial_bridge_pkg::reply_ack});
    end else begin
      stim_q.push_back({cmd, filler, filler});
      resp_q.push_back({serial_bridge_pkg::reply_idle, serial_bridge_pkg::reply_idle,
                        serial_bridge_pkg::reply_ack, model[idx]});
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // spi host model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // one byte msb first with n_rise rising edges
  // a short count leaves the byte incomplete and the bridge drops it when select goes high
  task automatic shift_byte(input logic [7:0] tx, input int n_rise, output logic [7:0] rx);
    rx = '0;
    for (int i = 0; i < 8 && i <= n_rise; i++) begin
      @(posedge clk);
      spi_sclk <= 1'b0;
      spi_mosi <= tx[7-i];
      repeat (spi_half - 1) @(posedge clk);
      // miso moved a few clocks after the falling edge and is stable here
      @(negedge clk);
      rx[7-i] = spi_miso;
      if (i < n_rise) begin
        @(posedge clk);
        spi_sclk <= 1'b1;
        repeat (spi_half - 1) @(posedge clk);
      end
    end
  endtask

  // the bridge loads its first reply when it sees select fall
  task automatic select_target();
    @(posedge clk);
    spi_csn <= 1'b0;
    repeat (spi_half) @(posedge clk);
  endtask

  task automatic deselect_target();
    @(posedge clk);
    spi_csn  <= 1'b1;
    spi_sclk <= 1'b0;
    spi_mosi <= 1'b0;
    repeat (2 * spi_half) @(posedge clk);
  endtask

  // the trailing byte stops before its eighth rising edge, so all its reply
  // bits are collected while the bridge never sees it as a new command
  task automatic run_transaction(input int entry, input logic [23:0] stim,
                                 input logic [31:0] resp);
    logic [7:0] got;
    logic [7:0] exp;
    select_target();
    for (int b = 0; b < 4; b++) begin
      if (b < 3) begin
        shift_byte(stim[23-8*b -: 8], 8, got);
      end else begin
        shift_byte(filler, 7, got);
      end
      exp = resp[31-8*b -: 8];
      check_count++;
      assert (got === exp) else begin
        error_count++;
        $display("MISMATCH at %0t ns: entry %0d byte %0d replied %02h, expected %02h",
                 $time, entry, b, got, exp);
      end
    end
    deselect_target();
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // test sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    logic [7:0] adr;
    logic [7:0] partial;
    rst_n    <= 1'b0;
    spi_sclk <= 1'b0;
    spi_csn  <= 1'b1;
    spi_mosi <= 1'b0;
    error_count = 0;
    check_count = 0;
    rnd = 32'h46ed_cbd4;
    for (int i = 0; i < serial_bridge_pkg::reg_count; i++) begin
      model[i] = 8'h00;
    end

    // every register reads zero straight after reset
    for (int i = 0; i < serial_bridge_pkg::reg_count; i++) begin
      add_entry(1'b0, 8'(i), 8'h00);
    end
    // one write per register with random bits in 6:4 on the odd ones
    for (int i = 0; i < serial_bridge_pkg::reg_count; i++) begin
      rnd = xorshift32(rnd);
      adr = 8'(i);
      if (i % 2 == 1) begin
        adr[6:4] = rnd[10:8];
      end
      add_entry(1'b1, adr, rnd[7:0]);
    end
    // read back everything with every third command through an alias
    for (int i = 0; i < serial_bridge_pkg::reg_count; i++) begin
      adr = 8'(i);
      if (i % 3 == 0) begin
        adr[6:4] = 3'b111;
      end
      add_entry(1'b0, adr, 8'h00);
    end
    // aliased overwrites that are each read back at once by their plain address
    for (int j = 0; j < 6; j++) begin
      rnd = xorshift32(rnd);
      add_entry(1'b1, {1'b0, rnd[14:12], rnd[3:0]}, rnd[23:16]);
      add_entry(1'b0, {4'h0, rnd[3:0]}, 8'h00);
    end

    // two more frames for the aborted byte and one read follow the table
    cycle_limit = (stim_q.size() + 2) * (4 * byte_cycles + frame_overhead) + 200;

    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    repeat (4) @(posedge clk);
    @(negedge clk);
    check_count++;
    assert (spi_miso === 1'b0) else begin
      error_count++;
      $display("MISMATCH at %0t ns: miso is %b after reset, expected 0", $time, spi_miso);
    end

    for (int n = 0; n < stim_q.size(); n++) begin
      run_transaction(n, stim_q[n], resp_q[n]);
    end

    // a write command cut off after three bits must change nothing
    rnd = xorshift32(rnd);
    select_target();
    shift_byte({4'h8, rnd[3:0]}, 3, partial);
    // the four bits seen before the abort come from an empty reply queue
    check_count++;
    assert (partial[7:4] === serial_bridge_pkg::reply_idle[7:4]) else begin
      error_count++;
      $display("MISMATCH at %0t ns: aborted byte replied %h, expected %h",
               $time, partial[7:4], serial_bridge_pkg::reply_idle[7:4]);
    end
    deselect_target();
    add_entry(1'b0, {4'h0, rnd[3:0]}, 8'h00);
    run_transaction(stim_q.size() - 1, stim_q[$], resp_q[$]);

    $display("checks run %0d, errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
